/* common/busy_mem_pkg.sv */
`default_nettype none

package busy_mem_pkg;

    // sizes
    localparam int MEM_WORDS = 64;    // ram depth in words
    localparam int INDEX_LSB = 2;     // word select inside the byte address
    localparam int INDEX_MSB = 7;

    typedef logic [31:0] word_t;       // data word
    typedef logic [31:0] mem_addr_t;   // byte address
    typedef logic [5:0]  word_index_t; // word index into the ram
    typedef logic [7:0]  delay_t;      // busy delay in cycles

    localparam delay_t DEFAULT_DELAY = 8'd2; // delay after reset
    localparam delay_t MIN_DELAY     = 8'd1; // smaller settings are raised to this

    // one access request
    typedef struct packed {
        mem_addr_t addr;
        logic      we;
        word_t     wdata;
    } mem_req_t;

    // port that owns the access in flight
    typedef enum logic {
        own_imem,
        own_dmem
    } owner_e;

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_e;

endpackage

`default_nettype wire

/* source/mem_delay.sv */
`default_nettype none

module mem_delay
    import busy_mem_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   valid,        // access request
    input  delay_t delay_cycles, // taken at each start
    output logic   ready,        // no access in progress
    output logic   start         // access accepted strobe
);

    delay_t count;
    delay_t limit;
    delay_t count_next;
    logic   idle;
    logic   last;

    assign idle  = (count == '0);
    assign last  = !idle && (count == limit);   // final busy cycle
    assign ready = idle;
    assign start = idle && valid;

    // count from 1 up to the latched limit, then wrap to zero
    always_comb begin
        count_next = count;
        if (start) begin
            count_next = delay_t'(1);
        end else if (last) begin
            count_next = '0;
        end else if (!idle) begin
            count_next = count + delay_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            limit <= '0;
        end else begin
            count <= count_next;
            if (start) begin
                limit <= delay_cycles; // later config writes do not affect this access
            end
        end
    end

endmodule

`default_nettype wire

/* busy_ram/ram_array.sv */
`default_nettype none

module ram_array
    import busy_mem_pkg::*;
(
    input  logic        clk,
    input  word_index_t index,
    input  logic        we,
    input  word_t       wdata,
    output word_t       rdata
);

    word_t mem [MEM_WORDS]; // contents are not cleared by reset

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index]; // asynchronous read

endmodule

`default_nettype wire

/* busy_ram/busy_ram.sv */
`default_nettype none

module busy_ram
    import busy_mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid,        // access request
    input  mem_req_t req,          // sampled on accept
    input  delay_t   delay_cycles,
    output logic     ready,
    output word_t    rdata
);

    mem_req_t    buf_req;   // request held for the whole access
    logic        start;
    logic        ready_q;
    logic        ram_we;
    word_index_t ram_index;

    // valid to ready delay
    mem_delay mem_delay_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid        (valid),
        .delay_cycles (delay_cycles),
        .ready        (ready),
        .start        (start)
    );

    // input request buffer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_req <= '0;
            ready_q <= 1'b1;
        end else begin
            ready_q <= ready;
            if (start) begin
                buf_req <= req;
            end
        end
    end

    // write once, in the cycle where ready comes back
    assign ram_we    = buf_req.we && ready && !ready_q;
    assign ram_index = buf_req.addr[INDEX_MSB:INDEX_LSB];

    ram_array ram_array_inst (
        .clk   (clk),
        .index (ram_index),
        .we    (ram_we),
        .wdata (buf_req.wdata),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

/* source/delay_config.sv */
`default_nettype none

module delay_config
    import busy_mem_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   cfg_we,       // one-cycle write strobe
    input  delay_t cfg_wdata,
    output delay_t delay_cycles, // to the busy ram
    output delay_t cfg_rdata     // read-back of the stored value
);

    delay_t delay_q;
    delay_t delay_clamped;

    // zero delay is not supported by the busy counter
    assign delay_clamped = (cfg_wdata < MIN_DELAY) ? MIN_DELAY : cfg_wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            delay_q <= DEFAULT_DELAY;
        end else if (cfg_we) begin
            delay_q <= delay_clamped;
        end
    end

    assign delay_cycles = delay_q;
    assign cfg_rdata    = delay_q; // shows the clamped value

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`default_nettype none

module mem_arbiter
    import busy_mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     req_imem,
    input  logic     req_dmem,
    input  mem_req_t imem_req,
    input  mem_req_t dmem_req,

    input  logic     mem_ready,
    input  word_t    mem_rdata,

    output logic     mem_valid,
    output mem_req_t mem_req,

    output logic     done_imem,
    output logic     done_dmem,
    output word_t    rdata_imem,
    output word_t    rdata_dmem
);

    arb_state_e state;
    arb_state_e state_next;
    owner_e     owner;
    logic       any_req;
    logic       finish;

    assign any_req = req_imem || req_dmem;

    // only start an access while idle and the ram is free
    assign mem_valid = (state == arb_idle) && any_req && mem_ready;
    assign mem_req   = req_dmem ? dmem_req : imem_req; // data port first

    assign finish = (state == arb_busy) && mem_ready;

    always_comb begin
        state_next = state;
        case (state)
            arb_idle: begin
                if (mem_valid) begin
                    state_next = arb_busy;
                end
            end
            arb_busy: begin
                if (finish) begin
                    state_next = arb_idle;
                end
            end
            default: state_next = arb_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= arb_idle;
            owner <= own_imem;
        end else begin
            state <= state_next;
            if (mem_valid) begin
                owner <= req_dmem ? own_dmem : own_imem;
            end
        end
    end

    // done pulse and read data go to the owner only
    assign done_imem  = finish && (owner == own_imem);
    assign done_dmem  = finish && (owner == own_dmem);
    assign rdata_imem = (owner == own_imem) ? mem_rdata : '0;
    assign rdata_dmem = (owner == own_dmem) ? mem_rdata : '0;

endmodule

`default_nettype wire

/* source/busy_mem_top.sv */
`default_nettype none

module busy_mem_top
    import busy_mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    // instruction port
    input  logic     req_imem,
    input  mem_req_t imem_req,
    output logic     done_imem,
    output word_t    rdata_imem,

    // data port
    input  logic     req_dmem,
    input  mem_req_t dmem_req,
    output logic     done_dmem,
    output word_t    rdata_dmem,

    // delay configuration
    input  logic     cfg_we,
    input  delay_t   cfg_wdata,
    output delay_t   cfg_rdata
);

    logic     mem_valid;
    logic     mem_ready;
    mem_req_t mem_req;
    word_t    mem_rdata;
    delay_t   delay_cycles;

    delay_config delay_config_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg_we       (cfg_we),
        .cfg_wdata    (cfg_wdata),
        .delay_cycles (delay_cycles),
        .cfg_rdata    (cfg_rdata)
    );

    mem_arbiter mem_arbiter_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_imem   (req_imem),
        .req_dmem   (req_dmem),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .done_imem  (done_imem),
        .done_dmem  (done_dmem),
        .rdata_imem (rdata_imem),
        .rdata_dmem (rdata_dmem)
    );

    busy_ram busy_ram_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid        (mem_valid),
        .req          (mem_req),
        .delay_cycles (delay_cycles),
        .ready        (mem_ready),
        .rdata        (mem_rdata)
    );

endmodule

`default_nettype wire

/* dv/busy_mem_tb.sv */
`default_nettype none

module busy_mem_tb
    import busy_mem_pkg::*;
();

    localparam int ACCESSES       = 48;                             // over all tests
    localparam int TIMEOUT_CYCLES = ACCESSES * (255 + 2 + 2) + 100; // worst delay per access

    logic     clk;
    logic     arst_n;
    logic     req_imem;
    logic     req_dmem;
    mem_req_t imem_req;
    mem_req_t dmem_req;
    logic     done_imem;
    logic     done_dmem;
    word_t    rdata_imem;
    word_t    rdata_dmem;
    logic     cfg_we;
    delay_t   cfg_wdata;
    delay_t   cfg_rdata;

    word_t  ref_mem [MEM_WORDS]; // reference memory model
    logic   known [MEM_WORDS];   // word written at least once
    int     error_count;
    int     check_count;
    int     test_count;
    int     test_errors;
    int     cycle_count;
    integer seed;

    busy_mem_top busy_mem_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_imem   (req_imem),
        .imem_req   (imem_req),
        .done_imem  (done_imem),
        .rdata_imem (rdata_imem),
        .req_dmem   (req_dmem),
        .dmem_req   (dmem_req),
        .done_dmem  (done_dmem),
        .rdata_dmem (rdata_dmem),
        .cfg_we     (cfg_we),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, an access never completed", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_delay(input string name, input delay_t got, input delay_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("%s took %0d cycles from req to done, expected %0d", what, got, exp);
        end
    endtask

    function automatic mem_req_t make_req(input mem_addr_t addr, input logic we,
                                          input word_t wdata);
        mem_req_t r;
        r.addr  = addr;
        r.we    = we;
        r.wdata = wdata;
        return r;
    endfunction

    task automatic start_test();
        test_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_errors)
            $display("test %s: pass", name);
        else
            $display("test %s: %0d errors", name, error_count - test_errors);
    endtask

    task automatic set_delay(input delay_t value);
        @(posedge clk);
        #2;
        cfg_we    = 1'b1;
        cfg_wdata = value;
        @(posedge clk);
        #2;
        cfg_we    = 1'b0;
    endtask

    // one access on one port; cycles counts from the req cycle to the done cycle
    task automatic access(input logic dport, input mem_req_t r, output word_t rdata,
                          output int cycles);
        @(posedge clk);
        #2;
        if (dport) begin
            req_dmem = 1'b1;
            dmem_req = r;
        end else begin
            req_imem = 1'b1;
            imem_req = r;
        end
        cycles = 0;
        @(negedge clk);
        while (!(dport ? done_dmem : done_imem)) begin
            @(negedge clk);
            cycles++;
        end
        rdata = dport ? rdata_dmem : rdata_imem;
        check_bit(dport ? "done_imem" : "done_dmem", dport ? done_imem : done_dmem, 1'b0);
        @(posedge clk);
        #2;
        req_dmem = 1'b0; // dropped in the cycle after done
        req_imem = 1'b0;
    endtask

    task automatic mem_op(input logic dport, input mem_addr_t addr, input logic we,
                          input word_t wdata, input int exp_cycles);
        word_t       rd;
        int          cycles;
        word_index_t idx;
        idx = addr[INDEX_MSB:INDEX_LSB];
        access(dport, make_req(addr, we, wdata), rd, cycles);
        if (we) begin
            ref_mem[idx] = wdata;
            known[idx]   = 1'b1;
        end else begin
            check_word(dport ? "rdata_dmem" : "rdata_imem", rd, ref_mem[idx]);
        end
        check_latency(we ? "write" : "read", cycles, exp_cycles);
    endtask

    task automatic reset_values();
        start_test();
        check_delay("cfg_rdata", cfg_rdata, 8'd2);
        repeat (5) begin
            @(negedge clk);
            check_bit("done_imem", done_imem, 1'b0);
            check_bit("done_dmem", done_dmem, 1'b0);
        end
        finish_test("reset values");
    endtask

    task automatic write_read_default();
        start_test();
        mem_op(1'b1, 32'h0000_0040, 1'b1, 32'hdead_beef, 3);
        mem_op(1'b1, 32'h0000_0040, 1'b0, 32'h0, 3);
        finish_test("dmem write then read");
    endtask

    task automatic config_clamp();
        start_test();
        set_delay(8'd0);
        check_delay("cfg_rdata", cfg_rdata, 8'd1); // zero is raised to the minimum
        mem_op(1'b1, 32'h0000_0044, 1'b1, 32'h1234_5678, 2);
        set_delay(8'd7);
        check_delay("cfg_rdata", cfg_rdata, 8'd7);
        mem_op(1'b0, 32'h0000_0044, 1'b0, 32'h0, 8);
        finish_test("config and clamping");
    endtask

    task automatic priority_order();
        int    cycles;
        int    dmem_at;
        int    imem_at;
        word_t rd;
        start_test();
        set_delay(8'd3);
        @(posedge clk);
        #2;
        req_dmem = 1'b1;
        dmem_req = make_req(32'h0000_0080, 1'b1, 32'ha5a5_0001);
        req_imem = 1'b1;
        imem_req = make_req(32'h0000_0080, 1'b0, 32'h0);
        cycles   = 0;
        dmem_at  = -1;
        imem_at  = -1;
        while (imem_at < 0) begin
            @(negedge clk);
            if (done_dmem && dmem_at < 0)
                dmem_at = cycles;
            if (done_imem) begin
                imem_at = cycles;
                rd      = rdata_imem;
            end
            @(posedge clk);
            #2;
            if (dmem_at >= 0)
                req_dmem = 1'b0;
            cycles++;
        end
        req_imem = 1'b0;
        ref_mem[32] = 32'ha5a5_0001; // dmem write lands before the imem read
        known[32]   = 1'b1;
        if (dmem_at < 0 || dmem_at >= imem_at) begin
            error_count++;
            $display("done_dmem did not come before done_imem with both ports requesting");
        end else begin
            check_latency("dmem access under contention", dmem_at, 4);
            check_latency("imem wait behind dmem", imem_at - dmem_at, 5);
        end
        check_word("rdata_imem", rd, ref_mem[32]);
        finish_test("priority");
    endtask

    task automatic random_traffic();
        logic        dport;
        logic        we;
        mem_addr_t   addr;
        word_t       wdata;
        word_t       rnd;
        word_index_t idx;
        start_test();
        set_delay(8'd1);
        for (int i = 0; i < 40; i++) begin
            rnd   = $random(seed);
            dport = rnd[0];
            addr  = $random(seed) & 32'hffff_ff3f; // bits 7 and 6 cleared, 16 words in use
            rnd   = $random(seed);
            we    = rnd[0];
            wdata = $random(seed);
            idx   = addr[INDEX_MSB:INDEX_LSB];
            if (!known[idx])
                we = 1'b1;
            mem_op(dport, addr, we, wdata, 2);
        end
        finish_test("random traffic");
    endtask

    task automatic delay_change_in_flight();
        start_test();
        set_delay(8'd3);
        fork
            mem_op(1'b1, 32'h0000_0048, 1'b1, 32'h0bad_cafe, 4);
            begin
                @(posedge clk); // lands one cycle into the access
                set_delay(8'd6);
            end
        join
        check_delay("cfg_rdata", cfg_rdata, 8'd6);
        mem_op(1'b1, 32'h0000_0048, 1'b0, 32'h0, 7);
        finish_test("delay change during access");
    endtask

    initial begin
        seed        = 32'h17906289;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        test_errors = 0;
        cycle_count = 0;
        arst_n      = 1'b0;
        req_imem    = 1'b0;
        req_dmem    = 1'b0;
        imem_req    = '0;
        dmem_req    = '0;
        cfg_we      = 1'b0;
        cfg_wdata   = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            known[i] = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        reset_values();
        write_read_default();
        config_clamp();
        priority_order();
        random_traffic();
        delay_change_in_flight();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
common/busy_mem_pkg.sv
source/mem_delay.sv
busy_ram/ram_array.sv
busy_ram/busy_ram.sv
source/delay_config.sv
source/mem_arbiter.sv
source/busy_mem_top.sv
dv/busy_mem_tb.sv

/* Bender.yml */
package:
  name: busy_mem

sources:
  - files:
      - common/busy_mem_pkg.sv
      - source/mem_delay.sv
      - busy_ram/ram_array.sv
      - busy_ram/busy_ram.sv
      - source/delay_config.sv
      - source/mem_arbiter.sv
      - source/busy_mem_top.sv
  - target: test
    files:
      - dv/busy_mem_tb.sv
